// ==== sources.f ====
verilog/vid_timing_pkg.sv
verilog/pxl_pkg.sv
verilog/vid_timing.sv
verilog/tile_layer.sv
verilog/obj_layer.sv
verilog/col_mix.sv
verilog/video_top.sv
verif/tb_video_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_video_top
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== verif/tb_video_top.sv ====
//****************************************
// Testbench for the video subsystem: random CPU setup,
// tile ROM model and per-pixel reference model
//****************************************

module tb_video_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_TOTAL   = 64;
    localparam int H_VIS     = 48;
    localparam int HS_START  = 52;
    localparam int HS_LEN    = 4;
    localparam int V_TOTAL   = 40;
    localparam int V_VIS     = 32;
    localparam int VS_START  = 35;
    localparam int VS_LEN    = 2;
    localparam int LAT       = vid_timing_pkg::PXL_LAT;
    localparam int FRAME     = H_TOTAL * V_TOTAL;
    localparam int UNIT_TILE = 0;
    localparam int UNIT_OBJ  = 1;
    localparam int UNIT_PAL  = 2;

    logic           clk;
    logic           reset;
    logic           pxl_cen;
    logic [7:0]     cpu_addr;
    logic [7:0]     cpu_dout;
    logic           cpu_we;
    logic           tile_cs;
    logic           obj_cs;
    logic           pal_we;
    logic [1:0]     cpu_prio;
    logic [3:0]     prog_addr;
    logic [1:0]     prog_data;
    logic           prom_we;
    logic [8:0]     tile_rom_addr;
    logic [31:0]    tile_rom_data;
    logic [7:0]     pal_dout;
    logic           cpu_irq_n;
    logic           lhbl;
    logic           lvbl;
    logic           hs;
    logic           vs;
    pxl_pkg::rgb5_t red;
    pxl_pkg::rgb5_t green;
    pxl_pkg::rgb5_t blue;

    // Shadow copies of everything the CPU writes
    logic [7:0] map_sh [64];
    logic [7:0] pal_sh [128];
    logic [1:0] prom_sh [16];
    logic [1:0] prio_sh;
    logic [7:0] spr_x [4];
    logic [7:0] spr_y [4];
    logic [4:0] spr_col [4];
    logic       spr_en [4];
    logic [8:0] rom_addr_q;
    int         tick_cnt;
    int         chk_cnt;
    int         err_cnt;
    int         test_cnt;
    int         chk_mark;
    int         err_mark;
    logic       seen;

    video_top #(
        .H_TOTAL  (H_TOTAL),
        .H_VIS    (H_VIS),
        .HS_START (HS_START),
        .HS_LEN   (HS_LEN),
        .V_TOTAL  (V_TOTAL),
        .V_VIS    (V_VIS),
        .VS_START (VS_START),
        .VS_LEN   (VS_LEN)
    ) i_video_top (
        .clk           (clk),
        .reset         (reset),
        .pxl_cen       (pxl_cen),
        .cpu_addr      (cpu_addr),
        .cpu_dout      (cpu_dout),
        .cpu_we        (cpu_we),
        .tile_cs       (tile_cs),
        .obj_cs        (obj_cs),
        .pal_we        (pal_we),
        .cpu_prio      (cpu_prio),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .prom_we       (prom_we),
        .tile_rom_addr (tile_rom_addr),
        .tile_rom_data (tile_rom_data),
        .pal_dout      (pal_dout),
        .cpu_irq_n     (cpu_irq_n),
        .lhbl          (lhbl),
        .lvbl          (lvbl),
        .hs            (hs),
        .vs            (vs),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

    // Graphics ROM contents, a hash of the address
    function automatic logic [31:0] rom_word(logic [8:0] addr);
        logic [31:0] x;
        x = (32'(addr) + 32'd1) * 32'h2545f491;
        return x ^ (x >> 15);
    endfunction

    always #2 clk = ~clk;

    // Pixel enable on every second clock
    always @(posedge clk) begin
        #1;
        pxl_cen <= ~pxl_cen;
    end

    // Ticks since reset give the raster position
    always @(posedge clk) begin
        if (reset)
            tick_cnt <= 0;
        else if (pxl_cen)
            tick_cnt <= tick_cnt + 1;
    end

    // ROM answers one clock after the address
    always @(posedge clk) begin
        rom_addr_q = tile_rom_addr;
        #1;
        tile_rom_data = rom_word(rom_addr_q);
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_rgb(string name, pxl_pkg::rgb5_t got, pxl_pkg::rgb5_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at tick %0d", name, got, exp, tick_cnt);
        end
    endtask

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at tick %0d", name, got, exp, tick_cnt);
        end
    endtask

    task automatic check_addr(string name, logic [8:0] got, logic [8:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at tick %0d", name, got, exp, tick_cnt);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at tick %0d", name, got, exp, tick_cnt);
        end
    endtask

    task automatic next_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_tick();
        int start;
        int guard;
        start = tick_cnt;
        guard = 0;
        while (tick_cnt == start) begin
            next_clock();
            guard++;
            if (guard > 8)
                abort_run("Timeout: no pixel tick within 8 clocks");
        end
    endtask

    task automatic bus_write(int unit, logic [7:0] addr, logic [7:0] data);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = (unit != UNIT_PAL);
        tile_cs  = (unit == UNIT_TILE);
        obj_cs   = (unit == UNIT_OBJ);
        pal_we   = (unit == UNIT_PAL);
        next_clock();
        cpu_we  = 1'b0;
        tile_cs = 1'b0;
        obj_cs  = 1'b0;
        pal_we  = 1'b0;
    endtask

    task automatic prom_write(logic [3:0] addr, logic [1:0] data);
        prom_sh[addr] = data;
        prog_addr = addr;
        prog_data = data;
        prom_we   = 1'b1;
        next_clock();
        prom_we = 1'b0;
    endtask

    task automatic load_map();
        for (int i = 0; i < 64; i++) begin
            map_sh[i] = 8'($urandom());
            bus_write(UNIT_TILE, 8'(i), map_sh[i]);
        end
    endtask

    task automatic set_sprite(int n, logic [7:0] x, logic [7:0] y, logic en, logic [4:0] col);
        spr_x[n]   = x;
        spr_y[n]   = y;
        spr_en[n]  = en;
        spr_col[n] = col;
        bus_write(UNIT_OBJ, 8'(n * 4), x);
        bus_write(UNIT_OBJ, 8'(n * 4 + 1), y);
        bus_write(UNIT_OBJ, 8'(n * 4 + 2), {en, 2'b00, col});
    endtask

    // Tile ROM address expected while the counters sit at tick k
    function automatic logic [8:0] model_rom_addr(int k);
        int         h;
        int         v;
        logic [7:0] ent;
        h   = k % H_TOTAL;
        v   = (k / H_TOTAL) % V_TOTAL;
        ent = map_sh[(v / 8) * 8 + h / 8];
        return {ent[5:0], 3'(v % 8)};
    endfunction

    // Expected {red, green, blue} for the position reached after k ticks
    function automatic logic [14:0] model_rgb(int k);
        int                  h;
        int                  v;
        logic [7:0]          ent;
        logic [31:0]         row;
        logic [3:0]          pen;
        logic [4:0]          ocol;
        logic                o_op;
        pxl_pkg::layer_sel_t sel;
        pxl_pkg::pal_idx_t   idx;
        logic [7:0]          lo;
        logic [7:0]          hi;
        h = k % H_TOTAL;
        v = (k / H_TOTAL) % V_TOTAL;
        if (k < 0 || h >= H_VIS || v >= V_VIS)
            return '0;
        ent  = map_sh[(v / 8) * 8 + h / 8];
        row  = rom_word({ent[5:0], 3'(v % 8)});
        pen  = row[(h % 8) * 4 +: 4];
        o_op = 1'b0;
        ocol = '0;
        // Walk down so sprite 0 is left standing
        for (int i = 3; i >= 0; i--) begin
            if (spr_en[i] && h >= spr_x[i] && h <= spr_x[i] + 7
                    && v >= spr_y[i] && v <= spr_y[i] + 7) begin
                o_op = 1'b1;
                ocol = spr_col[i];
            end
        end
        sel = pxl_pkg::layer_sel_t'(prom_sh[{prio_sh, pen != 4'd0, o_op}]);
        if (sel == pxl_pkg::LAYER_TILE)
            idx = {1'b0, ent[7], pen};
        else if (sel == pxl_pkg::LAYER_OBJ)
            idx = {1'b1, ocol};
        else
            idx = '0;
        lo = pal_sh[{idx, 1'b0}];
        hi = pal_sh[{idx, 1'b1}];
        return {lo[4:0], hi[1:0], lo[7:5], hi[6:2]};
    endfunction

    task automatic check_frame();
        logic [14:0] exp;
        // Let the last register writes pass through the pipeline
        repeat (LAT + 1)
            wait_tick();
        repeat (FRAME) begin
            wait_tick();
            check_addr("tile_rom_addr", tile_rom_addr, model_rom_addr(tick_cnt));
            exp = model_rgb(tick_cnt - LAT);
            check_rgb("red", red, exp[14:10]);
            check_rgb("green", green, exp[9:5]);
            check_rgb("blue", blue, exp[4:0]);
        end
    endtask

    task automatic finish_test(string name);
        test_cnt++;
        $display("%s: %0d checks, %0d errors", name, chk_cnt - chk_mark, err_cnt - err_mark);
        chk_mark = chk_cnt;
        err_mark = err_cnt;
    endtask

    initial begin
        int k;
        int h;
        int v;
        int guard;
        clk           = 1'b0;
        reset         = 1'b1;
        pxl_cen       = 1'b0;
        cpu_addr      = '0;
        cpu_dout      = '0;
        cpu_we        = 1'b0;
        tile_cs       = 1'b0;
        obj_cs        = 1'b0;
        pal_we        = 1'b0;
        cpu_prio      = '0;
        prog_addr     = '0;
        prog_data     = '0;
        prom_we       = 1'b0;
        tile_rom_data = '0;
        chk_cnt       = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        chk_mark      = 0;
        err_mark      = 0;
        void'($urandom(32'h78e037e2));
        repeat (2)
            @(posedge clk);
        #1;
        reset = 1'b0;

        // Sync and blanking, PXL_LAT ticks behind the counters
        repeat (2 * FRAME) begin
            wait_tick();
            k = tick_cnt - LAT;
            h = k % H_TOTAL;
            v = (k / H_TOTAL) % V_TOTAL;
            check_bit("lhbl", lhbl, k >= 0 && h < H_VIS);
            check_bit("lvbl", lvbl, k >= 0 && v < V_VIS);
            check_bit("hs", hs, k >= 0 && h >= HS_START && h < HS_START + HS_LEN);
            check_bit("vs", vs, k >= 0 && v >= VS_START && v < VS_START + VS_LEN);
        end
        finish_test("raster timing");

        for (int i = 0; i < 128; i++) begin
            pal_sh[i] = 8'($urandom());
            bus_write(UNIT_PAL, 8'(i), pal_sh[i]);
        end
        for (int i = 0; i < 128; i++) begin
            cpu_addr = 8'(i);
            next_clock();
            check_byte("pal_dout", pal_dout, pal_sh[i]);
        end
        finish_test("palette read-back");

        load_map();
        for (int i = 0; i < 4; i++)
            set_sprite(i, 8'd0, 8'd0, 1'b0, 5'd0);
        // Tile wins when opaque, backdrop otherwise
        for (int a = 0; a < 16; a++)
            prom_write(4'(a), a[1] ? 2'(pxl_pkg::LAYER_TILE) : 2'(pxl_pkg::LAYER_BACK));
        prio_sh  = 2'($urandom());
        cpu_prio = prio_sh;
        check_frame();
        finish_test("tiles only");

        repeat (2) begin
            load_map();
            set_sprite(0, 8'($urandom_range(0, 40)), 8'($urandom_range(0, 24)), 1'b1,
                       5'($urandom()));
            // Sprite 1 partly under sprite 0
            set_sprite(1, spr_x[0] + 8'($urandom_range(1, 6)), spr_y[0] + 8'($urandom_range(1, 6)),
                       1'b1, 5'($urandom()));
            set_sprite(2, 8'($urandom_range(0, 44)), 8'($urandom_range(0, 28)), 1'b1,
                       5'($urandom()));
            set_sprite(3, 8'($urandom_range(0, 44)), 8'($urandom_range(0, 28)), 1'($urandom()),
                       5'($urandom()));
            for (int a = 0; a < 16; a++)
                prom_write(4'(a), 2'($urandom()));
            prio_sh  = 2'($urandom());
            cpu_prio = prio_sh;
            check_frame();
        end
        finish_test("sprites over tiles");

        // Start the interrupt test well away from vblank
        guard = 0;
        while ((tick_cnt / H_TOTAL) % V_TOTAL != 1) begin
            wait_tick();
            guard++;
            if (guard > FRAME)
                abort_run("Timeout: raster never reached line 1 before the interrupt test");
        end
        bus_write(UNIT_TILE, 8'h40, 8'h00);
        check_bit("cpu_irq_n", cpu_irq_n, 1'b1);
        seen = 1'b0;
        repeat (2 * FRAME) begin
            wait_tick();
            if (tick_cnt % H_TOTAL == 0 && (tick_cnt / H_TOTAL) % V_TOTAL == V_VIS)
                seen = 1'b1;
            check_bit("cpu_irq_n", cpu_irq_n, ~seen);
        end
        bus_write(UNIT_TILE, 8'h40, 8'h00);
        check_bit("cpu_irq_n", cpu_irq_n, 1'b1);
        finish_test("interrupt");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog/video_top.sv ====
//****************************************
// Video subsystem top: raster timing, tile and
// sprite layers and colour mixer on one CPU bus
//****************************************

module video_top #(
    parameter int H_TOTAL  = 64,
    parameter int H_VIS    = 48,
    parameter int HS_START = 52,
    parameter int HS_LEN   = 4,
    parameter int V_TOTAL  = 40,
    parameter int V_VIS    = 32,
    parameter int VS_START = 35,
    parameter int VS_LEN   = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           pxl_cen,
    input  logic [7:0]     cpu_addr,
    input  logic [7:0]     cpu_dout,
    input  logic           cpu_we,
    input  logic           tile_cs,
    input  logic           obj_cs,
    input  logic           pal_we,
    input  logic [1:0]     cpu_prio,
    input  logic [3:0]     prog_addr,
    input  logic [1:0]     prog_data,
    input  logic           prom_we,
    output logic [8:0]     tile_rom_addr,
    input  logic [31:0]    tile_rom_data,
    output logic [7:0]     pal_dout,
    output logic           cpu_irq_n,
    output logic           lhbl,
    output logic           lvbl,
    output logic           hs,
    output logic           vs,
    output pxl_pkg::rgb5_t red,
    output pxl_pkg::rgb5_t green,
    output pxl_pkg::rgb5_t blue
);

    vid_timing_pkg::hpos_t hpos;
    vid_timing_pkg::vpos_t vpos;
    pxl_pkg::tile_pxl_t    tile_pxl;
    pxl_pkg::obj_pxl_t     obj_pxl;
    logic                  tile_opaque;
    logic                  obj_opaque;

    vid_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_VIS    (H_VIS),
        .HS_START (HS_START),
        .HS_LEN   (HS_LEN),
        .V_TOTAL  (V_TOTAL),
        .V_VIS    (V_VIS),
        .VS_START (VS_START),
        .VS_LEN   (VS_LEN)
    ) i_vid_timing (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .hpos    (hpos),
        .vpos    (vpos),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs      (hs),
        .vs      (vs)
    );

    tile_layer #(
        .V_VIS (V_VIS)
    ) i_tile_layer (
        .clk           (clk),
        .reset         (reset),
        .pxl_cen       (pxl_cen),
        .hpos          (hpos),
        .vpos          (vpos),
        .cpu_addr      (cpu_addr),
        .cpu_dout      (cpu_dout),
        .cpu_we        (cpu_we),
        .tile_cs       (tile_cs),
        .tile_rom_addr (tile_rom_addr),
        .tile_rom_data (tile_rom_data),
        .tile_pxl      (tile_pxl),
        .tile_opaque   (tile_opaque),
        .irq_n         (cpu_irq_n)
    );

    obj_layer i_obj_layer (
        .clk        (clk),
        .reset      (reset),
        .pxl_cen    (pxl_cen),
        .hpos       (hpos),
        .vpos       (vpos),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_we     (cpu_we),
        .obj_cs     (obj_cs),
        .obj_pxl    (obj_pxl),
        .obj_opaque (obj_opaque)
    );

    col_mix i_col_mix (
        .clk         (clk),
        .reset       (reset),
        .pxl_cen     (pxl_cen),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .cpu_prio    (cpu_prio),
        .tile_pxl    (tile_pxl),
        .tile_opaque (tile_opaque),
        .obj_pxl     (obj_pxl),
        .obj_opaque  (obj_opaque),
        .cpu_addr    (cpu_addr),
        .cpu_dout    (cpu_dout),
        .pal_we      (pal_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prom_we     (prom_we),
        .pal_dout    (pal_dout),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

// ==== verilog/col_mix.sv ====
//****************************************
// Colour mixer: priority PROM picks the layer,
// palette RAM turns the index into 5:5:5 RGB
//****************************************

module col_mix (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic               lhbl,
    input  logic               lvbl,
    input  logic [1:0]         cpu_prio,
    input  pxl_pkg::tile_pxl_t tile_pxl,
    input  logic               tile_opaque,
    input  pxl_pkg::obj_pxl_t  obj_pxl,
    input  logic               obj_opaque,
    input  logic [7:0]         cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               pal_we,
    input  logic [3:0]         prog_addr,
    input  logic [1:0]         prog_data,
    input  logic               prom_we,
    output logic [7:0]         pal_dout,
    output pxl_pkg::rgb5_t     red,
    output pxl_pkg::rgb5_t     green,
    output pxl_pkg::rgb5_t     blue
);

    logic [1:0]          prom [16];
    logic [7:0]          pal_ram [128];
    pxl_pkg::layer_sel_t sel;
    pxl_pkg::pal_idx_t   idx_nxt;
    pxl_pkg::pal_idx_t   pal_idx;
    logic [7:0]          pal_lo;
    logic [7:0]          pal_hi;
    pxl_pkg::rgb5_t      red_q;
    pxl_pkg::rgb5_t      green_q;
    pxl_pkg::rgb5_t      blue_q;

    always_ff @(posedge clk) begin
        if (prom_we)
            prom[prog_addr] <= prog_data;
    end

    // CPU side of the palette, read-back one clock after the address
    always_ff @(posedge clk) begin
        if (pal_we)
            pal_ram[cpu_addr[6:0]] <= cpu_dout;
        pal_dout <= pal_ram[cpu_addr[6:0]];
    end

    assign sel = pxl_pkg::layer_sel_t'(prom[{cpu_prio, tile_opaque, obj_opaque}]);

    always_comb begin
        case (sel)
            pxl_pkg::LAYER_TILE: idx_nxt = {1'b0, tile_pxl};
            pxl_pkg::LAYER_OBJ:  idx_nxt = {1'b1, obj_pxl};
            default:             idx_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (pxl_cen)
            pal_idx <= idx_nxt;
    end

    // Even byte: green low bits and red; odd byte: blue and green high bits
    assign pal_lo = pal_ram[{pal_idx, 1'b0}];
    assign pal_hi = pal_ram[{pal_idx, 1'b1}];

    always_ff @(posedge clk) begin
        if (reset) begin
            red_q   <= '0;
            green_q <= '0;
            blue_q  <= '0;
        end else if (pxl_cen) begin
            red_q   <= pal_lo[4:0];
            green_q <= {pal_hi[1:0], pal_lo[7:5]};
            blue_q  <= pal_hi[6:2];
        end
    end

    // Blanking is already delayed to the output stage
    assign red   = (lhbl && lvbl) ? red_q : '0;
    assign green = (lhbl && lvbl) ? green_q : '0;
    assign blue  = (lhbl && lvbl) ? blue_q : '0;

endmodule

// ==== verilog/obj_layer.sv ====
//****************************************
// Four solid 8x8 sprites from CPU registers,
// lowest numbered sprite wins on overlap
//****************************************

module obj_layer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  vid_timing_pkg::hpos_t hpos,
    input  vid_timing_pkg::vpos_t vpos,
    input  logic [7:0]            cpu_addr,
    input  logic [7:0]            cpu_dout,
    input  logic                  cpu_we,
    input  logic                  obj_cs,
    output pxl_pkg::obj_pxl_t     obj_pxl,
    output logic                  obj_opaque
);

    logic [7:0]        obj_x [4];
    logic [7:0]        obj_y [4];
    logic [4:0]        obj_col [4];
    logic [3:0]        obj_en;
    logic [3:0]        hit;
    pxl_pkg::obj_pxl_t hit_col;
    logic [1:0]        obj_sel;
    logic              obj_wr;

    assign obj_sel = cpu_addr[3:2];
    assign obj_wr  = obj_cs & cpu_we;

    always_ff @(posedge clk) begin
        if (obj_wr) begin
            case (cpu_addr[1:0])
                2'd0:    obj_x[obj_sel] <= cpu_dout;
                2'd1:    obj_y[obj_sel] <= cpu_dout;
                2'd2:    obj_col[obj_sel] <= cpu_dout[4:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            obj_en <= '0;
        else if (obj_wr && cpu_addr[1:0] == 2'd2)
            obj_en[obj_sel] <= cpu_dout[7];
    end

    // 9-bit compare so a sprite near 255 does not wrap
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hit[i] = obj_en[i]
                && (hpos >= {1'b0, obj_x[i]}) && (hpos <= {1'b0, obj_x[i]} + 9'd7)
                && (vpos >= {1'b0, obj_y[i]}) && (vpos <= {1'b0, obj_y[i]} + 9'd7);
        end
        hit_col = '0;
        for (int i = 3; i >= 0; i--) begin
            if (hit[i])
                hit_col = obj_col[i];
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen)
            obj_pxl <= hit_col;
    end

    always_ff @(posedge clk) begin
        if (reset)
            obj_opaque <= 1'b0;
        else if (pxl_cen)
            obj_opaque <= |hit;
    end

endmodule

// ==== verilog/tile_layer.sv ====
//****************************************
// Tilemap layer with CPU map RAM and graphics ROM fetch,
// also raises the vertical blank interrupt
//****************************************

module tile_layer #(
    parameter int V_VIS = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  vid_timing_pkg::hpos_t hpos,
    input  vid_timing_pkg::vpos_t vpos,
    input  logic [7:0]            cpu_addr,
    input  logic [7:0]            cpu_dout,
    input  logic                  cpu_we,
    input  logic                  tile_cs,
    output logic [8:0]            tile_rom_addr,
    input  logic [31:0]           tile_rom_data,
    output pxl_pkg::tile_pxl_t    tile_pxl,
    output logic                  tile_opaque,
    output logic                  irq_n
);

    // Map entry keeps the bank in bit 6 and the tile code below it
    logic [6:0] map_ram [64];
    logic [6:0] map_rd;
    logic [3:0] pen;
    logic       map_we;
    logic       irq_ack;
    logic       vbl_start;
    logic       irq_flag;

    assign map_we  = tile_cs & cpu_we & ~cpu_addr[6];
    assign irq_ack = tile_cs & cpu_we & cpu_addr[6];

    always_ff @(posedge clk) begin
        if (map_we)
            map_ram[cpu_addr[5:0]] <= {cpu_dout[7], cpu_dout[5:0]};
    end

    // Address is stable for the whole tick, ROM answers before the next one
    assign map_rd        = map_ram[{vpos[5:3], hpos[5:3]}];
    assign tile_rom_addr = {map_rd[5:0], vpos[2:0]};
    assign pen           = tile_rom_data[{hpos[2:0], 2'b00} +: 4];

    always_ff @(posedge clk) begin
        if (pxl_cen)
            tile_pxl <= {map_rd[6], pen};
    end

    always_ff @(posedge clk) begin
        if (reset)
            tile_opaque <= 1'b0;
        else if (pxl_cen)
            tile_opaque <= pen != 4'd0;
    end

    // First pixel of the first blanked line
    assign vbl_start = (vpos == vid_timing_pkg::vpos_t'(V_VIS)) && (hpos == '0);

    always_ff @(posedge clk) begin
        if (reset)
            irq_flag <= 1'b0;
        else if (irq_ack)
            irq_flag <= 1'b0;
        else if (pxl_cen && vbl_start)
            irq_flag <= 1'b1;
    end

    // Low as soon as the counters reach vblank, flag holds it after that
    assign irq_n = ~(irq_flag | vbl_start);

endmodule

// ==== verilog/vid_timing.sv ====
//****************************************
// Raster timing generator: pixel and line counters,
// blanking and sync delayed to match the colour path
//****************************************

module vid_timing #(
    parameter int H_TOTAL  = 64,
    parameter int H_VIS    = 48,
    parameter int HS_START = 52,
    parameter int HS_LEN   = 4,
    parameter int V_TOTAL  = 40,
    parameter int V_VIS    = 32,
    parameter int VS_START = 35,
    parameter int VS_LEN   = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    output vid_timing_pkg::hpos_t hpos,
    output vid_timing_pkg::vpos_t vpos,
    output logic                  lhbl,
    output logic                  lvbl,
    output logic                  hs,
    output logic                  vs
);

    localparam int LAT = vid_timing_pkg::PXL_LAT;

    // Bit order in the delay chain: lhbl, lvbl, hs, vs
    logic [3:0] raw_ctl;
    logic [3:0] ctl_dly [LAT];

    always_ff @(posedge clk) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else if (pxl_cen) begin
            if (hpos == vid_timing_pkg::hpos_t'(H_TOTAL - 1)) begin
                hpos <= '0;
                if (vpos == vid_timing_pkg::vpos_t'(V_TOTAL - 1))
                    vpos <= '0;
                else
                    vpos <= vpos + 9'd1;
            end else begin
                hpos <= hpos + 9'd1;
            end
        end
    end

    assign raw_ctl[3] = hpos < H_VIS;
    assign raw_ctl[2] = vpos < V_VIS;
    assign raw_ctl[1] = (hpos >= HS_START) && (hpos < HS_START + HS_LEN);
    assign raw_ctl[0] = (vpos >= VS_START) && (vpos < VS_START + VS_LEN);

    // Same depth as the pixel pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LAT; i++)
                ctl_dly[i] <= '0;
        end else if (pxl_cen) begin
            ctl_dly[0] <= raw_ctl;
            for (int i = 1; i < LAT; i++)
                ctl_dly[i] <= ctl_dly[i-1];
        end
    end

    assign lhbl = ctl_dly[LAT-1][3];
    assign lvbl = ctl_dly[LAT-1][2];
    assign hs   = ctl_dly[LAT-1][1];
    assign vs   = ctl_dly[LAT-1][0];

endmodule

// ==== verilog/pxl_pkg.sv ====
//****************************************
// Layer pixel, palette and colour types used
// between the layers and the colour mixer
//****************************************

package pxl_pkg;

    // Palette bank in bit 4, pen in bits 3:0; pen 0 is transparent
    typedef logic [4:0] tile_pxl_t;

    // Sprite colour, opacity travels separately
    typedef logic [4:0] obj_pxl_t;

    // Palette entry, two bytes each in palette RAM
    typedef logic [5:0] pal_idx_t;

    // One 5-bit colour channel
    typedef logic [4:0] rgb5_t;

    // Priority PROM result
    typedef enum logic [1:0] {
        LAYER_BACK = 2'd0,
        LAYER_TILE = 2'd1,
        LAYER_OBJ  = 2'd2
    } layer_sel_t;

endpackage

// ==== verilog/vid_timing_pkg.sv ====
//****************************************
// Raster position types shared by the timing
// generator, both layers and the colour mixer
//****************************************

package vid_timing_pkg;

    // Pixel counter within a line
    typedef logic [8:0] hpos_t;

    // Line counter within a frame
    typedef logic [8:0] vpos_t;

    // Pixel ticks from raster position to colour at the outputs
    localparam int PXL_LAT = 3;

endpackage
